/* verilog/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// datapath geometry.
`define CORE_DATA_W     32
`define CORE_REG_COUNT  16
`define CORE_PTR_W      4

// instruction field positions, 4 bits each.
`define INSN_OPC_LSB    28
`define INSN_DST_LSB    24
`define INSN_SRC0_LSB   20
`define INSN_SRC1_LSB   16
`define INSN_SRC2_LSB   12

// opcodes, F1 then F2.
`define OPC_NOP         4'd0
`define OPC_ADD         4'd1
`define OPC_SUB         4'd2
`define OPC_AND         4'd3
`define OPC_OR          4'd4
`define OPC_XOR         4'd5
`define OPC_MAC         4'd8
`define OPC_MSB         4'd9

`endif

/* verilog/core_pkg.sv */
`include "core_consts.svh"

package core_pkg;

    // operation selected by the decoder.
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_mac = 3'd5,
        op_msb = 3'd6
    } core_op_e;

    // decoded word as held in the FD stage.
    typedef struct packed {
        logic                   valid;
        logic                   is_f1;
        logic                   is_f2;
        core_op_e               op;
        logic [`CORE_PTR_W-1:0] dst;
        logic [`CORE_PTR_W-1:0] src0;
        logic [`CORE_PTR_W-1:0] src1;
        logic [`CORE_PTR_W-1:0] src2;
    } fd_insn_t;

    // write-back record of the MW stage.
    typedef struct packed {
        logic                    valid;
        logic [`CORE_PTR_W-1:0]  dst;
        logic [`CORE_DATA_W-1:0] result;
    } mw_wb_t;

endpackage

/* verilog/insn_decoder.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module insn_decoder (
    input  logic [`CORE_DATA_W-1:0] insn,
    output core_pkg::fd_insn_t      dec
);
    import core_pkg::*;

    localparam int unsigned PTR_W = `CORE_PTR_W;

    logic [3:0] opc;

    assign opc = insn[`INSN_OPC_LSB +: 4];

    always_comb begin
        dec      = '0;
        dec.dst  = insn[`INSN_DST_LSB  +: PTR_W];
        dec.src0 = insn[`INSN_SRC0_LSB +: PTR_W];
        dec.src1 = insn[`INSN_SRC1_LSB +: PTR_W];
        dec.src2 = insn[`INSN_SRC2_LSB +: PTR_W];
        case (opc)
            `OPC_ADD: begin
                dec.is_f1 = 1'b1;
                dec.op    = op_add;
            end
            `OPC_SUB: begin
                dec.is_f1 = 1'b1;
                dec.op    = op_sub;
            end
            `OPC_AND: begin
                dec.is_f1 = 1'b1;
                dec.op    = op_and;
            end
            `OPC_OR: begin
                dec.is_f1 = 1'b1;
                dec.op    = op_or;
            end
            `OPC_XOR: begin
                dec.is_f1 = 1'b1;
                dec.op    = op_xor;
            end
            `OPC_MAC: begin
                dec.is_f2 = 1'b1;
                dec.op    = op_mac;
            end
            `OPC_MSB: begin
                dec.is_f2 = 1'b1;
                dec.op    = op_msb;
            end
            // nop and undefined codes write nothing.
            default: begin
                dec.op = op_add;
            end
        endcase
        dec.valid = dec.is_f1 || dec.is_f2;
    end

    always_comb begin
        a_one_class: assert (!(dec.is_f1 && dec.is_f2))
            else $error("word 0x%08h decoded as both F1 and F2", insn);
    end

endmodule

/* verilog/exec_unit.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module exec_unit (
    input  core_pkg::core_op_e      op,
    input  logic [`CORE_DATA_W-1:0] a,
    input  logic [`CORE_DATA_W-1:0] b,
    input  logic [`CORE_DATA_W-1:0] c,
    output logic [`CORE_DATA_W-1:0] result
);
    import core_pkg::*;

    logic [`CORE_DATA_W-1:0] prod;

    // only the low half of b*c is kept.
    assign prod = b * c;

    always_comb begin
        case (op)
            op_add: begin
                result = a + b;
            end
            op_sub: begin
                result = a - b;
            end
            op_and: begin
                result = a & b;
            end
            op_or: begin
                result = a | b;
            end
            op_xor: begin
                result = a ^ b;
            end
            op_mac: begin
                result = a + prod;
            end
            op_msb: begin
                result = a - prod;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    clear_regs,
    input  logic                    init_r0,
    input  logic [`CORE_DATA_W-1:0] init_r0_data,
    input  core_pkg::mw_wb_t        wb,
    input  logic [`CORE_PTR_W-1:0]  src0_ptr,
    input  logic [`CORE_PTR_W-1:0]  src1_ptr,
    input  logic [`CORE_PTR_W-1:0]  src2_ptr,
    output logic [`CORE_DATA_W-1:0] src0_data,
    output logic [`CORE_DATA_W-1:0] src1_data,
    output logic [`CORE_DATA_W-1:0] src2_data
);
    localparam int unsigned PTR_W     = `CORE_PTR_W;
    localparam int unsigned REG_COUNT = `CORE_REG_COUNT;

    logic [`CORE_DATA_W-1:0] regs    [REG_COUNT];
    logic [`CORE_DATA_W-1:0] wr_data [REG_COUNT];
    logic [REG_COUNT-1:0]    wr_en;

    // per-register enables. r0 also takes the init strobe, which wins.
    for (genvar i = 0; i < REG_COUNT; i++) begin : g_wr
        if (i == 0) begin : g_r0
            assign wr_en[i]   = init_r0 || (wb.valid && (wb.dst == PTR_W'(i)));
            assign wr_data[i] = init_r0 ? init_r0_data : wb.result;
        end else begin : g_rn
            assign wr_en[i]   = wb.valid && (wb.dst == PTR_W'(i));
            assign wr_data[i] = wb.result;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < REG_COUNT; i++) begin
                if (clear_regs) begin
                    regs[i] <= '0;
                end else if (wr_en[i]) begin
                    regs[i] <= wr_data[i];
                end
            end
        end
    end

    // read ports are plain muxes.
    assign src0_data = regs[src0_ptr];
    assign src1_data = regs[src1_ptr];
    assign src2_data = regs[src2_ptr];

    a_write_lands: assert property (
        @(posedge clk) disable iff (!arst_n)
        (wb.valid && !clear_regs && !(init_r0 && (wb.dst == '0)))
            |=> (regs[$past(wb.dst)] == $past(wb.result))
    ) else $error("register %0d did not take write-back data", $past(wb.dst));

endmodule

/* verilog/core_top.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module core_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    insn_valid,
    input  logic [`CORE_DATA_W-1:0] insn,
    input  logic                    init_r0,
    input  logic [`CORE_DATA_W-1:0] init_r0_data,
    input  logic                    clear_regs,
    output logic                    wb_valid,
    output logic [`CORE_PTR_W-1:0]  wb_dst,
    output logic [`CORE_DATA_W-1:0] wb_data
);
    import core_pkg::*;

    fd_insn_t dec;
    fd_insn_t fd_q;
    mw_wb_t   mw_q;

    logic [`CORE_DATA_W-1:0] rf_src0;
    logic [`CORE_DATA_W-1:0] rf_src1;
    logic [`CORE_DATA_W-1:0] rf_src2;
    logic [`CORE_DATA_W-1:0] op_a;
    logic [`CORE_DATA_W-1:0] op_b;
    logic [`CORE_DATA_W-1:0] op_c;
    logic [`CORE_DATA_W-1:0] ex_result;

    // newest value wins. mw holds the one instruction not yet in the file.
    function automatic logic [`CORE_DATA_W-1:0] bypass(
        input mw_wb_t                  mw,
        input logic [`CORE_PTR_W-1:0]  ptr,
        input logic [`CORE_DATA_W-1:0] rf_data
    );
        if (mw.valid && (mw.dst == ptr)) begin
            return mw.result;
        end
        return rf_data;
    endfunction

    insn_decoder u_insn_decoder (
        .insn (insn),
        .dec  (dec)
    );

    // fd stage.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fd_q <= '0;
        end else begin
            fd_q       <= dec;
            fd_q.valid <= insn_valid && dec.valid;
        end
    end

    reg_file u_reg_file (
        .clk          (clk),
        .arst_n       (arst_n),
        .clear_regs   (clear_regs),
        .init_r0      (init_r0),
        .init_r0_data (init_r0_data),
        .wb           (mw_q),
        .src0_ptr     (fd_q.src0),
        .src1_ptr     (fd_q.src1),
        .src2_ptr     (fd_q.src2),
        .src0_data    (rf_src0),
        .src1_data    (rf_src1),
        .src2_data    (rf_src2)
    );

    assign op_a = bypass(mw_q, fd_q.src0, rf_src0);
    assign op_b = bypass(mw_q, fd_q.src1, rf_src1);
    assign op_c = bypass(mw_q, fd_q.src2, rf_src2);

    exec_unit u_exec_unit (
        .op     (fd_q.op),
        .a      (op_a),
        .b      (op_b),
        .c      (op_c),
        .result (ex_result)
    );

    // mw stage, also the write-back port.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mw_q <= '0;
        end else begin
            mw_q.valid  <= fd_q.valid;
            mw_q.dst    <= fd_q.dst;
            mw_q.result <= ex_result;
        end
    end

    assign wb_valid = mw_q.valid;
    assign wb_dst   = mw_q.dst;
    assign wb_data  = mw_q.result;

    a_no_spurious_wb: assert property (
        @(posedge clk) disable iff (!arst_n)
        !fd_q.valid |=> !wb_valid
    ) else $error("write-back without an instruction in FD");

endmodule

/* verif/tb_core_top.sv */
`timescale 1ns/1ns
`include "core_consts.svh"

module tb_core_top;
    localparam int TEST_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 200;

    typedef struct packed {
        logic [31:0] stamp;
        logic [3:0]  dst;
        logic [31:0] data;
    } exp_wb_t;

    logic        clk;
    logic        arst_n;
    logic        insn_valid;
    logic [31:0] insn;
    logic        init_r0;
    logic [31:0] init_r0_data;
    logic        clear_regs;
    logic        wb_valid;
    logic [3:0]  wb_dst;
    logic [31:0] wb_data;

    integer      seed = 32'h2ef74dff;
    logic [31:0] cycle_cnt = '0;
    logic [31:0] model_regs [16];
    exp_wb_t     exp_q [$];

    core_top u_core_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 32'd1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: simulation hung after %0d cycles", cycle_cnt);
            $display("FAIL: see errors above");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] model_result(
        input logic [3:0]  opc,
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [31:0] c
    );
        logic [63:0] prod;
        prod = {32'd0, b} * {32'd0, c};
        case (opc)
            `OPC_ADD: return a + b;
            `OPC_SUB: return a - b;
            `OPC_AND: return a & b;
            `OPC_OR:  return a | b;
            `OPC_XOR: return a ^ b;
            `OPC_MAC: return a + prod[31:0];
            `OPC_MSB: return a - prod[31:0];
            default:  return '0;
        endcase
    endfunction

    function automatic logic writes_reg(input logic [3:0] opc);
        return (opc >= `OPC_ADD && opc <= `OPC_XOR) || opc == `OPC_MAC || opc == `OPC_MSB;
    endfunction

    function automatic logic [31:0] rand_word(input logic [3:0] opc);
        logic [31:0] r;
        r = $random(seed);
        return {opc, r[27:0]};
    endfunction

    function automatic logic [3:0] pick_opc(input logic f1_only);
        logic [31:0] r;
        r = $random(seed);
        r = r % (f1_only ? 32'd5 : 32'd7);
        return (r < 32'd5) ? `OPC_ADD + r[3:0] : `OPC_MAC + r[3:0] - 4'd5;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic drive_insn(input logic valid, input logic [31:0] word);
        exp_wb_t e;
        insn_valid = valid;
        insn       = word;
        if (valid && writes_reg(word[31:28])) begin
            // sampled at the next edge, on wb two edges later.
            e.stamp = cycle_cnt + 32'd2;
            e.dst   = word[27:24];
            e.data  = model_result(word[31:28], model_regs[word[23:20]],
                                   model_regs[word[19:16]], model_regs[word[15:12]]);
            model_regs[e.dst] = e.data;
            exp_q.push_back(e);
        end
        @(posedge clk);
        #1;
    endtask

    // r0 load or full clear, with the pipe drained first.
    task automatic side_strobe(input logic clear, input logic [31:0] data);
        repeat (2) drive_insn(1'b0, $random(seed));
        insn_valid   = 1'b0;
        clear_regs   = clear;
        init_r0      = !clear;
        init_r0_data = data;
        for (int i = 0; i < 16; i++) begin
            if (clear || i == 0)
                model_regs[i] = clear ? '0 : data;
        end
        @(posedge clk);
        #1;
        clear_regs = 1'b0;
        init_r0    = 1'b0;
    endtask

    task automatic seed_regs();
        logic [31:0] w;
        for (int i = 1; i < 16; i++) begin
            side_strobe(1'b0, $random(seed));
            w = rand_word(`OPC_OR);
            w[27:16] = {4'(i), 8'd0};
            drive_insn(1'b1, w);
        end
        side_strobe(1'b0, $random(seed));
    endtask

    // second word reads the first one's dst after a gap of 0 to 2 cycles.
    task automatic dep_pair();
        logic [31:0] first;
        logic [31:0] second;
        logic [31:0] r;
        first  = rand_word(pick_opc(1'b0));
        second = rand_word(pick_opc(1'b0));
        r      = $random(seed);
        case (r[1:0])
            2'd0:    second[23:20] = first[27:24];
            2'd1:    second[19:16] = first[27:24];
            2'd2:    second[15:12] = first[27:24];
            default: second[23:12] = {3{first[27:24]}};
        endcase
        drive_insn(1'b1, first);
        repeat (r[3:2] % 2'd3) drive_insn(1'b0, $random(seed));
        drive_insn(1'b1, second);
    endtask

    always @(negedge clk) begin : wb_monitor
        exp_wb_t e;
        if (arst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected write-back to r%0d at %0t ns with nothing pending",
                         wb_dst, $time);
                $display("FAIL: see errors above");
                $fatal(1, "spurious write-back");
            end else begin
                e = exp_q.pop_front();
                check_eq("write-back cycle", cycle_cnt, e.stamp);
                check_eq("wb_dst", {28'd0, wb_dst}, {28'd0, e.dst});
                check_eq("wb_data", wb_data, e.data);
            end
        end else if (arst_n && exp_q.size() != 0 && exp_q[0].stamp <= cycle_cnt) begin
            check_eq("wb_valid", {31'd0, wb_valid}, 32'd1);
        end
    end

    initial begin
        logic [31:0] w;
        logic [31:0] r;
        for (int i = 0; i < 16; i++)
            model_regs[i] = '0;
        arst_n       = 1'b0;
        insn_valid   = 1'b0;
        insn         = '0;
        init_r0      = 1'b0;
        init_r0_data = '0;
        clear_regs   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;

        seed_regs();
        repeat (400) drive_insn(1'b1, rand_word(pick_opc(1'b1)));

        // f2, every fourth word with one register in all sources.
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            w = rand_word(r[0] ? `OPC_MSB : `OPC_MAC);
            if (i % 4 == 0)
                w[23:12] = {3{w[23:20]}};
            drive_insn(1'b1, w);
        end

        repeat (150) dep_pair();

        // any opcode, valid or not.
        repeat (250) begin
            r = $random(seed);
            w = rand_word(r[7:4]);
            if (r[10:8] == 3'd0)
                w[31:28] = `OPC_NOP;
            drive_insn(r[1:0] != 2'd0, w);
        end

        repeat (4) begin
            side_strobe(1'b0, $random(seed));
            repeat (6) begin
                w = rand_word(pick_opc(1'b0));
                w[23:20] = 4'd0;
                drive_insn(1'b1, w);
            end
        end

        // clear, then read all registers back through xor.
        side_strobe(1'b1, '0);
        for (int i = 0; i < 16; i++) begin
            w = rand_word(`OPC_XOR);
            w[27:16] = {4'(i), 4'(i), 4'(i + 1)};
            drive_insn(1'b1, w);
        end

        seed_regs();
        repeat (100) drive_insn(1'b1, rand_word(pick_opc(1'b0)));
        repeat (3) drive_insn(1'b0, $random(seed));

        if (exp_q.size() != 0) begin
            $display("%0d write-backs never arrived", exp_q.size());
            $display("FAIL: see errors above");
            $fatal(1, "missing write-backs");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

/* files.f */
+incdir+verilog
verilog/core_pkg.sv
verilog/insn_decoder.sv
verilog/exec_unit.sv
verilog/reg_file.sv
verilog/core_top.sv
verif/tb_core_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
